//--- hw/exu_pkg.sv
// shared widths and operation codes for the execute stage, referenced by scoped name
`default_nettype none

package exu_pkg;

  // data word
  localparam int XLEN = 64;

  // alu operation codes
  localparam int ALU_OP_W = 5;
  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 5'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 5'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 5'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 5'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 5'd4;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 5'd5;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 5'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 5'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 5'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 5'd9;
  localparam logic [ALU_OP_W-1:0] ALU_MUL    = 5'd10;
  localparam logic [ALU_OP_W-1:0] ALU_DIV    = 5'd11;
  localparam logic [ALU_OP_W-1:0] ALU_DIVU   = 5'd12;
  localparam logic [ALU_OP_W-1:0] ALU_REM    = 5'd13;
  localparam logic [ALU_OP_W-1:0] ALU_REMU   = 5'd14;
  // immediate passes straight through (lui)
  localparam logic [ALU_OP_W-1:0] ALU_COPY   = 5'd15;
  localparam logic [ALU_OP_W-1:0] ALU_MULH   = 5'd25;
  localparam logic [ALU_OP_W-1:0] ALU_MULHSU = 5'd26;
  localparam logic [ALU_OP_W-1:0] ALU_MULHU  = 5'd27;

  // branch codes
  localparam int BR_W = 3;
  localparam logic [BR_W-1:0] BR_NONE = 3'd0;
  localparam logic [BR_W-1:0] BR_JAL  = 3'd1;
  localparam logic [BR_W-1:0] BR_JALR = 3'd2;
  localparam logic [BR_W-1:0] BR_EQ   = 3'd4;
  localparam logic [BR_W-1:0] BR_NE   = 3'd5;
  localparam logic [BR_W-1:0] BR_LT   = 3'd6;
  localparam logic [BR_W-1:0] BR_GE   = 3'd7;

  // load extension codes
  localparam int MEM_W = 3;
  localparam logic [MEM_W-1:0] MEM_LB  = 3'd0;
  localparam logic [MEM_W-1:0] MEM_LBU = 3'd1;
  localparam logic [MEM_W-1:0] MEM_LH  = 3'd2;
  localparam logic [MEM_W-1:0] MEM_LHU = 3'd3;
  localparam logic [MEM_W-1:0] MEM_LW  = 3'd4;
  localparam logic [MEM_W-1:0] MEM_LWU = 3'd5;
  localparam logic [MEM_W-1:0] MEM_LD  = 3'd6;

  // operand b select
  localparam int SRCB_W = 2;
  localparam logic [SRCB_W-1:0] SRCB_RS2  = 2'd0;
  localparam logic [SRCB_W-1:0] SRCB_IMM  = 2'd1;
  localparam logic [SRCB_W-1:0] SRCB_FOUR = 2'd2;

  // execute controls where any other value is a no-op
  localparam int EXC_W = 4;
  localparam logic [EXC_W-1:0] EXC_CSRW   = 4'd0;
  localparam logic [EXC_W-1:0] EXC_EBREAK = 4'd14;

endpackage

`default_nettype wire

//--- hw/exu_ctrl_if.sv
// decoded execute controls, driven by the top level and read by the stage
`timescale 1ns/1ps
`default_nettype none

interface exu_ctrl_if;

  logic                         a_pc;
  logic [exu_pkg::SRCB_W-1:0]   b_src;
  logic [exu_pkg::ALU_OP_W-1:0] alu_op;
  logic                         word_cut;
  logic [exu_pkg::BR_W-1:0]     branch;
  logic [exu_pkg::MEM_W-1:0]    mem_op;
  logic                         mem_to_reg;
  logic                         sel_csr;
  logic [exu_pkg::EXC_W-1:0]    ex_ctrl;
  logic                         illegal;

  modport source (
    output a_pc, b_src, alu_op, word_cut, branch,
    output mem_op, mem_to_reg, sel_csr, ex_ctrl, illegal
  );

  modport sink (
    input a_pc, b_src, alu_op, word_cut, branch,
    input mem_op, mem_to_reg, sel_csr, ex_ctrl, illegal
  );

endinterface

`default_nettype wire

//--- hw/exu_alu.sv
// combinational ALU of the execute stage, including multiply, divide and word variants
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  wire logic [exu_pkg::XLEN-1:0]     i_rs1,
  input  wire logic [exu_pkg::XLEN-1:0]     i_rs2,
  input  wire logic [exu_pkg::XLEN-1:0]     i_imm,
  input  wire logic [exu_pkg::XLEN-1:0]     i_pc,
  input  wire logic                         i_a_pc,
  input  wire logic [exu_pkg::SRCB_W-1:0]   i_b_src,
  input  wire logic [exu_pkg::ALU_OP_W-1:0] i_alu_op,
  input  wire logic                         i_word_cut,
  output logic      [exu_pkg::XLEN-1:0]     o_result,
  output logic      [exu_pkg::XLEN-1:0]     o_src_a,
  output logic                              o_zero,
  output logic                              o_less
);

  logic [exu_pkg::XLEN-1:0] src1, src2, imm;
  logic [exu_pkg::XLEN-1:0] src_a, src_b;
  logic [exu_pkg::XLEN-1:0] add_res, sub_res;
  logic                     signed_less, unsigned_less;
  logic [5:0]               shamt;
  logic [exu_pkg::XLEN-1:0] sra_a, sll_res, srl_res, sra_res;
  logic [2*exu_pkg::XLEN-1:0]        prod_uu;
  logic signed [2*exu_pkg::XLEN-1:0] prod_ss, prod_su;
  logic [exu_pkg::XLEN-1:0] div_a, div_b, div_b_safe, ub_safe;
  logic                     b_zero, div_ovf;
  logic [exu_pkg::XLEN-1:0] sdiv_q, sdiv_r, udiv_q, udiv_r;
  logic [exu_pkg::XLEN-1:0] res;

  // word ops see only the zero-extended low half
  assign src1 = i_word_cut ? {32'd0, i_rs1[31:0]} : i_rs1;
  assign src2 = i_word_cut ? {32'd0, i_rs2[31:0]} : i_rs2;
  assign imm  = i_word_cut ? {32'd0, i_imm[31:0]} : i_imm;

  assign src_a = i_a_pc ? i_pc : src1;

  always_comb begin
    case (i_b_src)
      exu_pkg::SRCB_RS2:  src_b = src2;
      exu_pkg::SRCB_IMM:  src_b = imm;
      exu_pkg::SRCB_FOUR: src_b = 64'd4;
      default:            src_b = '0;
    endcase
  end

  assign add_res = src_a + src_b;
  assign sub_res = src_a - src_b;

  assign signed_less   = $signed(src_a) < $signed(src_b);
  assign unsigned_less = src_a < src_b;

  assign o_zero = (sub_res == '0);
  assign o_less = (i_alu_op == exu_pkg::ALU_SLTU) ? unsigned_less : signed_less;

  // W shifts use 5 bits of shift amount
  assign shamt = i_word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];
  // sraw works on the sign-extended low word
  assign sra_a   = i_word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign sll_res = src_a << shamt;
  assign srl_res = src_a >> shamt;
  assign sra_res = $signed(sra_a) >>> shamt;

  // full 128-bit products with the high half used by mulh*
  assign prod_ss = $signed(src_a) * $signed(src_b);
  assign prod_su = $signed({src_a[63], src_a}) * $signed({1'b0, src_b});
  assign prod_uu = src_a * src_b;

  // signed word divide sees sign-extended operands
  assign div_a = i_word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign div_b = i_word_cut ? {{32{src_b[31]}}, src_b[31:0]} : src_b;

  assign b_zero  = (src_b == '0);
  assign div_ovf = (div_a == {1'b1, 63'd0}) && (&div_b);

  // divisor of 1 yields min / 0 for overflow, and keeps the divider defined
  assign div_b_safe = (b_zero || div_ovf) ? 64'd1 : div_b;
  assign ub_safe    = b_zero ? 64'd1 : src_b;

  assign sdiv_q = $signed(div_a) / $signed(div_b_safe);
  assign sdiv_r = $signed(div_a) % $signed(div_b_safe);
  assign udiv_q = src_a / ub_safe;
  assign udiv_r = src_a % ub_safe;

  always_comb begin
    case (i_alu_op)
      exu_pkg::ALU_ADD:    res = add_res;
      exu_pkg::ALU_SUB:    res = sub_res;
      exu_pkg::ALU_SLT:    res = {63'd0, signed_less};
      exu_pkg::ALU_SLTU:   res = {63'd0, unsigned_less};
      exu_pkg::ALU_XOR:    res = src_a ^ src_b;
      exu_pkg::ALU_AND:    res = src_a & src_b;
      exu_pkg::ALU_OR:     res = src_a | src_b;
      exu_pkg::ALU_SLL:    res = sll_res;
      exu_pkg::ALU_SRL:    res = srl_res;
      exu_pkg::ALU_SRA:    res = sra_res;
      exu_pkg::ALU_MUL:    res = prod_uu[63:0];
      exu_pkg::ALU_MULH:   res = prod_ss[127:64];
      exu_pkg::ALU_MULHSU: res = prod_su[127:64];
      exu_pkg::ALU_MULHU:  res = prod_uu[127:64];
      // divide by zero gives all ones and leaves the dividend as remainder
      exu_pkg::ALU_DIV:    res = b_zero ? '1 : sdiv_q;
      exu_pkg::ALU_DIVU:   res = b_zero ? '1 : udiv_q;
      exu_pkg::ALU_REM:    res = b_zero ? div_a : sdiv_r;
      exu_pkg::ALU_REMU:   res = b_zero ? src_a : udiv_r;
      exu_pkg::ALU_COPY:   res = i_imm;
      default:             res = '0;
    endcase
  end

  // word results sign-extend from bit 31
  assign o_result = i_word_cut ? {{32{res[31]}}, res[31:0]} : res;
  assign o_src_a  = src_a;

endmodule

`default_nettype wire

//--- hw/exu_branch.sv
// branch decision and next-PC adder for jal, jalr and the compare branches
`timescale 1ns/1ps
`default_nettype none

module exu_branch (
  input  wire logic [exu_pkg::BR_W-1:0] i_branch,
  input  wire logic                     i_zero,
  input  wire logic                     i_less,
  input  wire logic [exu_pkg::XLEN-1:0] i_pc,
  input  wire logic [exu_pkg::XLEN-1:0] i_rs1,
  input  wire logic [exu_pkg::XLEN-1:0] i_imm,
  output logic      [exu_pkg::XLEN-1:0] o_next_pc
);

  logic                     taken;
  logic [exu_pkg::XLEN-1:0] base;
  logic [exu_pkg::XLEN-1:0] offset;

  always_comb begin
    case (i_branch)
      exu_pkg::BR_JAL:  taken = 1'b1;
      exu_pkg::BR_JALR: taken = 1'b1;
      exu_pkg::BR_EQ:   taken = i_zero;
      exu_pkg::BR_NE:   taken = ~i_zero;
      exu_pkg::BR_LT:   taken = i_less;
      exu_pkg::BR_GE:   taken = ~i_less;
      default:          taken = 1'b0;
    endcase
  end

  // jalr adds to rs1, everything else to the pc
  assign base   = (i_branch == exu_pkg::BR_JALR) ? i_rs1 : i_pc;
  assign offset = taken ? i_imm : 64'd4;

  assign o_next_pc = base + offset;

endmodule

`default_nettype wire

//--- hw/exu_writeback.sv
// load extension, register write-back select and CSR write data
`timescale 1ns/1ps
`default_nettype none

module exu_writeback (
  input  wire logic [exu_pkg::MEM_W-1:0] i_mem_op,
  input  wire logic                      i_mem_to_reg,
  input  wire logic                      i_sel_csr,
  input  wire logic [exu_pkg::EXC_W-1:0] i_ex_ctrl,
  input  wire logic [exu_pkg::XLEN-1:0]  i_rdata,
  input  wire logic [exu_pkg::XLEN-1:0]  i_alu_result,
  input  wire logic [exu_pkg::XLEN-1:0]  i_rs2,
  input  wire logic [exu_pkg::XLEN-1:0]  i_src_a,
  output logic      [exu_pkg::XLEN-1:0]  o_gpr_wdata,
  output logic      [exu_pkg::XLEN-1:0]  o_csr_wdata
);

  logic [exu_pkg::XLEN-1:0] load_data;

  always_comb begin
    case (i_mem_op)
      exu_pkg::MEM_LB:  load_data = {{56{i_rdata[7]}}, i_rdata[7:0]};
      exu_pkg::MEM_LBU: load_data = {56'd0, i_rdata[7:0]};
      exu_pkg::MEM_LH:  load_data = {{48{i_rdata[15]}}, i_rdata[15:0]};
      exu_pkg::MEM_LHU: load_data = {48'd0, i_rdata[15:0]};
      exu_pkg::MEM_LW:  load_data = {{32{i_rdata[31]}}, i_rdata[31:0]};
      exu_pkg::MEM_LWU: load_data = {32'd0, i_rdata[31:0]};
      exu_pkg::MEM_LD:  load_data = i_rdata;
      default:          load_data = '0;
    endcase
  end

  // load first, then old csr value (arrives on rs2), then alu
  always_comb begin
    if (i_mem_to_reg) begin
      o_gpr_wdata = load_data;
    end else if (i_sel_csr) begin
      o_gpr_wdata = i_rs2;
    end else begin
      o_gpr_wdata = i_alu_result;
    end
  end

  assign o_csr_wdata = (i_ex_ctrl == exu_pkg::EXC_CSRW) ? i_src_a : '0;

endmodule

`default_nettype wire

//--- hw/exu_stage.sv
// execute stage datapath with its one-cycle output register and status flags
`timescale 1ns/1ps
`default_nettype none

module exu_stage (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_valid,
  exu_ctrl_if.sink                      ctrl,
  input  wire logic [exu_pkg::XLEN-1:0] i_rs1,
  input  wire logic [exu_pkg::XLEN-1:0] i_rs2,
  input  wire logic [exu_pkg::XLEN-1:0] i_imm,
  input  wire logic [exu_pkg::XLEN-1:0] i_pc,
  input  wire logic [exu_pkg::XLEN-1:0] i_rdata,
  output logic                          o_valid,
  output logic      [exu_pkg::XLEN-1:0] o_alu_result,
  output logic      [exu_pkg::XLEN-1:0] o_next_pc,
  output logic      [exu_pkg::XLEN-1:0] o_gpr_wdata,
  output logic      [exu_pkg::XLEN-1:0] o_csr_wdata,
  output logic                          o_halt,
  output logic                          o_illegal
);

  logic [exu_pkg::XLEN-1:0] alu_result, src_a, next_pc, gpr_wdata, csr_wdata;
  logic                     zero, less;

  exu_alu u_alu (
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .i_imm      (i_imm),
    .i_pc       (i_pc),
    .i_a_pc     (ctrl.a_pc),
    .i_b_src    (ctrl.b_src),
    .i_alu_op   (ctrl.alu_op),
    .i_word_cut (ctrl.word_cut),
    .o_result   (alu_result),
    .o_src_a    (src_a),
    .o_zero     (zero),
    .o_less     (less)
  );

  exu_branch u_branch (
    .i_branch  (ctrl.branch),
    .i_zero    (zero),
    .i_less    (less),
    .i_pc      (i_pc),
    .i_rs1     (i_rs1),
    .i_imm     (i_imm),
    .o_next_pc (next_pc)
  );

  exu_writeback u_writeback (
    .i_mem_op     (ctrl.mem_op),
    .i_mem_to_reg (ctrl.mem_to_reg),
    .i_sel_csr    (ctrl.sel_csr),
    .i_ex_ctrl    (ctrl.ex_ctrl),
    .i_rdata      (i_rdata),
    .i_alu_result (alu_result),
    .i_rs2        (i_rs2),
    .i_src_a      (src_a),
    .o_gpr_wdata  (gpr_wdata),
    .o_csr_wdata  (csr_wdata)
  );

  // flags last one cycle while data holds until the next strobe
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid      <= 1'b0;
      o_halt       <= 1'b0;
      o_illegal    <= 1'b0;
      o_alu_result <= '0;
      o_next_pc    <= '0;
      o_gpr_wdata  <= '0;
      o_csr_wdata  <= '0;
    end else begin
      o_valid   <= i_valid;
      o_halt    <= i_valid && (ctrl.ex_ctrl == exu_pkg::EXC_EBREAK);
      o_illegal <= i_valid && ctrl.illegal;
      if (i_valid) begin
        o_alu_result <= alu_result;
        o_next_pc    <= next_pc;
        o_gpr_wdata  <= gpr_wdata;
        o_csr_wdata  <= csr_wdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/exu_top.sv
// top level of the execute stage, plain ports packed into the control interface
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset,
  input  wire logic                         i_valid,
  input  wire logic [exu_pkg::XLEN-1:0]     i_rs1,
  input  wire logic [exu_pkg::XLEN-1:0]     i_rs2,
  input  wire logic [exu_pkg::XLEN-1:0]     i_imm,
  input  wire logic [exu_pkg::XLEN-1:0]     i_pc,
  input  wire logic [exu_pkg::XLEN-1:0]     i_rdata,
  input  wire logic                         i_a_pc,
  input  wire logic [exu_pkg::SRCB_W-1:0]   i_b_src,
  input  wire logic [exu_pkg::ALU_OP_W-1:0] i_alu_op,
  input  wire logic                         i_word_cut,
  input  wire logic [exu_pkg::BR_W-1:0]     i_branch,
  input  wire logic [exu_pkg::MEM_W-1:0]    i_mem_op,
  input  wire logic                         i_mem_to_reg,
  input  wire logic                         i_sel_csr,
  input  wire logic [exu_pkg::EXC_W-1:0]    i_ex_ctrl,
  input  wire logic                         i_illegal,
  output logic                              o_valid,
  output logic      [exu_pkg::XLEN-1:0]     o_alu_result,
  output logic      [exu_pkg::XLEN-1:0]     o_next_pc,
  output logic      [exu_pkg::XLEN-1:0]     o_gpr_wdata,
  output logic      [exu_pkg::XLEN-1:0]     o_csr_wdata,
  output logic                              o_halt,
  output logic                              o_illegal
);

  exu_ctrl_if u_ctrl ();

  assign u_ctrl.a_pc       = i_a_pc;
  assign u_ctrl.b_src      = i_b_src;
  assign u_ctrl.alu_op     = i_alu_op;
  assign u_ctrl.word_cut   = i_word_cut;
  assign u_ctrl.branch     = i_branch;
  assign u_ctrl.mem_op     = i_mem_op;
  assign u_ctrl.mem_to_reg = i_mem_to_reg;
  assign u_ctrl.sel_csr    = i_sel_csr;
  assign u_ctrl.ex_ctrl    = i_ex_ctrl;
  assign u_ctrl.illegal    = i_illegal;

  exu_stage u_stage (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .ctrl         (u_ctrl.sink),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_imm        (i_imm),
    .i_pc         (i_pc),
    .i_rdata      (i_rdata),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_next_pc    (o_next_pc),
    .o_gpr_wdata  (o_gpr_wdata),
    .o_csr_wdata  (o_csr_wdata),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

endmodule

`default_nettype wire

//--- testbench/exu_top_assert.sv
// concurrent checks on the execute top level flags and latency, attached by bind
`timescale 1ns/1ps
`default_nettype none

module exu_top_assert (
  input wire logic i_clk,
  input wire logic i_reset,
  input wire logic i_valid,
  input wire logic o_valid,
  input wire logic o_halt,
  input wire logic o_illegal
);

  // flags only ever come with a result
  a_halt_valid : assert property (@(posedge i_clk) disable iff (i_reset) o_halt |-> o_valid)
    else $error("o_halt high without o_valid");
  a_ill_valid : assert property (@(posedge i_clk) disable iff (i_reset) o_illegal |-> o_valid)
    else $error("o_illegal high without o_valid");

  // one cycle latency both ways
  a_lat_on : assert property (@(posedge i_clk) disable iff (i_reset) i_valid |=> o_valid)
    else $error("strobe not followed by o_valid");
  a_lat_off : assert property (@(posedge i_clk) disable iff (i_reset) !i_valid |=> !o_valid)
    else $error("o_valid without a strobe");

endmodule

bind exu_top exu_top_assert u_assert (
  .i_clk     (i_clk),
  .i_reset   (i_reset),
  .i_valid   (i_valid),
  .o_valid   (o_valid),
  .o_halt    (o_halt),
  .o_illegal (o_illegal)
);

`default_nettype wire

//--- testbench/tb_exu_top.sv
// table-driven testbench for the execute stage top level, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;

  typedef struct packed {
    logic [63:0] rs1, rs2, imm, pc, rdata;
    logic       a_pc;
    logic [1:0] b_src;
    logic [4:0] alu_op;
    logic       wc;
    logic [2:0] br;
    logic [2:0] mem_op;
    logic       m2r, csr;
    logic [3:0] exc;
    logic       ill;
  } entry_t;

  logic i_clk = 1'b0, i_reset, i_valid;
  logic [63:0] i_rs1, i_rs2, i_imm, i_pc, i_rdata;
  logic i_a_pc, i_word_cut, i_mem_to_reg, i_sel_csr, i_illegal;
  logic [1:0] i_b_src;
  logic [4:0] i_alu_op;
  logic [2:0] i_branch, i_mem_op;
  logic [3:0] i_ex_ctrl;
  logic o_valid, o_halt, o_illegal;
  logic [63:0] o_alu_result, o_next_pc, o_gpr_wdata, o_csr_wdata;

  entry_t tbl [0:199];
  integer n = 0, seed = 32'hb41f, errors = 0, passed = 0, failed = 0;
  integer cycles = 0, limit = 100000, pend, i, op, k;
  logic [63:0] pa [0:2];
  logic [63:0] pb [0:2];

  exu_top UUT (.*);

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  function logic [63:0] rnd();
    rnd = {$random(seed), $random(seed)};
  endfunction

  function logic [63:0] op_a(entry_t e);
    op_a = e.a_pc ? e.pc : e.rs1;
  endfunction

  function logic [63:0] op_b(entry_t e);
    case (e.b_src)
      2'd0: op_b = e.rs2;
      2'd1: op_b = e.imm;
      2'd2: op_b = 64'd4;
      default: op_b = 64'd0;
    endcase
  endfunction

  function logic [63:0] ref_alu(entry_t e);
    logic [63:0] a, b, r;
    logic [31:0] a32, b32, r32;
    logic signed [63:0] sa, sb, sq, sr;
    logic signed [31:0] sa32, sb32, sq32, sr32;
    logic [127:0] p;
    a = op_a(e);
    b = op_b(e);
    a32 = a[31:0];
    b32 = b[31:0];
    sa = a;
    sb = b;
    sa32 = a32;
    sb32 = b32;
    r = 64'd0;
    r32 = 32'd0;
    // signed quotient and remainder, only where the divide is defined
    sq = '0;
    sr = '0;
    sq32 = '0;
    sr32 = '0;
    if (b != 0 && !(a == {1'b1, 63'd0} && &b)) begin
      sq = sa / sb;
      sr = sa % sb;
    end
    if (b32 != 0 && !(a32 == 32'h8000_0000 && &b32)) begin
      sq32 = sa32 / sb32;
      sr32 = sa32 % sb32;
    end
    if (e.wc) begin
      case (e.alu_op)
        0: r32 = a32 + b32;
        1: r32 = a32 - b32;
        7: r32 = a32 << b32[4:0];
        8: r32 = a32 >> b32[4:0];
        9: r32 = sa32 >>> b32[4:0];
        10: r32 = a32 * b32;
        11: r32 = (b32 == 0) ? '1 : (a32 == 32'h8000_0000 && &b32) ? a32 : sq32;
        12: r32 = (b32 == 0) ? '1 : a32 / b32;
        13: r32 = (b32 == 0) ? a32 : (a32 == 32'h8000_0000 && &b32) ? 32'd0 : sr32;
        14: r32 = (b32 == 0) ? a32 : a32 % b32;
        default: r32 = 32'd0;
      endcase
      ref_alu = {{32{r32[31]}}, r32};
    end else begin
      case (e.alu_op)
        0: r = a + b;
        1: r = a - b;
        2: r = {63'd0, sa < sb};
        3: r = {63'd0, a < b};
        4: r = a ^ b;
        5: r = a & b;
        6: r = a | b;
        7: r = a << b[5:0];
        8: r = a >> b[5:0];
        9: r = sa >>> b[5:0];
        10: r = a * b;
        11: r = (b == 0) ? '1 : (a == {1'b1, 63'd0} && &b) ? a : sq;
        12: r = (b == 0) ? '1 : a / b;
        13: r = (b == 0) ? a : (a == {1'b1, 63'd0} && &b) ? 64'd0 : sr;
        14: r = (b == 0) ? a : a % b;
        15: r = e.imm;
        25: begin
          p = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
          r = p[127:64];
        end
        26: begin
          p = $signed({{64{a[63]}}, a}) * $signed({64'd0, b});
          r = p[127:64];
        end
        27: begin
          p = {64'd0, a} * {64'd0, b};
          r = p[127:64];
        end
        default: r = 64'd0;
      endcase
      ref_alu = r;
    end
  endfunction

  function logic [63:0] ref_next_pc(entry_t e);
    logic less, eq, taken;
    eq = (op_a(e) == op_b(e));
    less = (e.alu_op == 5'd3) ? (op_a(e) < op_b(e)) : ($signed(op_a(e)) < $signed(op_b(e)));
    case (e.br)
      1, 2: taken = 1'b1;
      4: taken = eq;
      5: taken = !eq;
      6: taken = less;
      7: taken = !less;
      default: taken = 1'b0;
    endcase
    if (e.br == 3'd2) ref_next_pc = e.rs1 + e.imm;
    else ref_next_pc = e.pc + (taken ? e.imm : 64'd4);
  endfunction

  function logic [63:0] ref_gpr(entry_t e);
    logic [63:0] d;
    d = e.rdata;
    case (e.mem_op)
      0: d = {{56{d[7]}}, d[7:0]};
      1: d = {56'd0, d[7:0]};
      2: d = {{48{d[15]}}, d[15:0]};
      3: d = {48'd0, d[15:0]};
      4: d = {{32{d[31]}}, d[31:0]};
      5: d = {32'd0, d[31:0]};
      6: d = e.rdata;
      default: d = 64'd0;
    endcase
    ref_gpr = e.m2r ? d : e.csr ? e.rs2 : ref_alu(e);
  endfunction

  task new_entry();
    tbl[n] = '0;
    tbl[n].rs1 = rnd();
    tbl[n].rs2 = rnd();
    tbl[n].imm = rnd();
    tbl[n].pc = rnd();
    tbl[n].rdata = rnd();
    tbl[n].exc = 4'd15;
  endtask

  task add_alu(input [4:0] aop, input wc, input [1:0] bs, input [63:0] a, input [63:0] b);
    new_entry();
    tbl[n].alu_op = aop;
    tbl[n].wc = wc;
    tbl[n].b_src = bs;
    tbl[n].rs1 = a;
    tbl[n].rs2 = b;
    tbl[n].imm = b;
    n = n + 1;
  endtask

  task add_br(input [2:0] br, input [4:0] aop, input [63:0] a, input [63:0] b);
    new_entry();
    tbl[n].br = br;
    tbl[n].alu_op = aop;
    tbl[n].rs1 = a;
    tbl[n].rs2 = b;
    n = n + 1;
  endtask

  task add_wb(input [2:0] mop, input m2r, input sc, input [3:0] exc, input ill, input apc);
    new_entry();
    tbl[n].b_src = 2'd2;
    tbl[n].mem_op = mop;
    tbl[n].m2r = m2r;
    tbl[n].csr = sc;
    tbl[n].exc = exc;
    tbl[n].ill = ill;
    tbl[n].a_pc = apc;
    n = n + 1;
  endtask

  task drive(input entry_t e);
    i_valid = 1'b1;
    {i_rs1, i_rs2, i_imm, i_pc, i_rdata} = {e.rs1, e.rs2, e.imm, e.pc, e.rdata};
    {i_a_pc, i_b_src, i_alu_op, i_word_cut} = {e.a_pc, e.b_src, e.alu_op, e.wc};
    {i_branch, i_mem_op, i_mem_to_reg, i_sel_csr} = {e.br, e.mem_op, e.m2r, e.csr};
    i_ex_ctrl = e.exc;
    i_illegal = e.ill;
  endtask

  task compare(input string what, input [63:0] got, input [63:0] exp, inout integer bad);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
      bad = bad + 1;
    end
  endtask

  task check_idle();
    if (o_valid !== 1'b0 || o_halt !== 1'b0 || o_illegal !== 1'b0) begin
      $display("error at %0t: idle cycle showed valid %b halt %b illegal %b",
               $time, o_valid, o_halt, o_illegal);
      errors = errors + 1;
    end
  endtask

  task check_entry(input integer idx);
    integer bad;
    bad = 0;
    if (o_valid !== 1'b1) begin
      $display("test %0d produced no result one cycle after its strobe", idx);
      bad = bad + 1;
    end
    compare("alu_result", o_alu_result, ref_alu(tbl[idx]), bad);
    compare("next_pc", o_next_pc, ref_next_pc(tbl[idx]), bad);
    compare("gpr_wdata", o_gpr_wdata, ref_gpr(tbl[idx]), bad);
    compare("csr_wdata", o_csr_wdata, (tbl[idx].exc == 4'd0) ? op_a(tbl[idx]) : 64'd0, bad);
    compare("halt", {63'd0, o_halt}, {63'd0, tbl[idx].exc == 4'd14}, bad);
    compare("illegal", {63'd0, o_illegal}, {63'd0, tbl[idx].ill}, bad);
    errors = errors + bad;
    if (bad == 0) passed = passed + 1;
    else failed = failed + 1;
    $display("test %0d op %0d br %0d: %s", idx, tbl[idx].alu_op, tbl[idx].br,
             (bad == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    i_reset = 1'b1;
    i_valid = 1'b0;
    drive('0);
    i_valid = 1'b0;
    // random and corner alu entries
    for (op = 0; op < 28; op = op + 1) begin
      if (op <= 15 || op >= 25) begin
        add_alu(op, 0, 2'd0, rnd(), rnd());
        add_alu(op, 0, 2'd1, rnd(), rnd());
      end
      if (op <= 1 || (op >= 7 && op <= 14))
        add_alu(op, 1, 2'd0, rnd(), rnd());
    end
    for (op = 11; op <= 14; op = op + 1) begin
      add_alu(op, 0, 2'd0, rnd(), 64'd0);
      add_alu(op, 1, 2'd0, rnd(), 64'hffff_ffff_0000_0000);
    end
    add_alu(11, 0, 2'd0, {1'b1, 63'd0}, '1);
    add_alu(13, 0, 2'd0, {1'b1, 63'd0}, '1);
    add_alu(11, 1, 2'd0, 64'h8000_0000, 64'hffff_ffff);
    add_alu(13, 1, 2'd0, 64'h8000_0000, 64'hffff_ffff);
    for (op = 7; op <= 9; op = op + 1) begin
      add_alu(op, 0, 2'd0, 64'h8765_4321_8000_0001, 64'd31);
      add_alu(op, 0, 2'd0, 64'h8765_4321_8000_0001, 64'd32);
      add_alu(op, 0, 2'd0, 64'h8765_4321_8000_0001, 64'd63);
      add_alu(op, 1, 2'd0, 64'h1234_5678_8000_0001, 64'd31);
    end
    add_alu(2, 0, 2'd0, '1, 64'd1);
    add_alu(3, 0, 2'd0, '1, 64'd1);
    add_alu(25, 0, 2'd0, -64'sd5, 64'd7);
    add_alu(26, 0, 2'd0, -64'sd5, 64'd7);
    // branches with equal, less and greater operands
    pa[0] = 64'd9;
    pb[0] = 64'd9;
    pa[1] = -64'sd3;
    pb[1] = 64'd5;
    pa[2] = 64'd5;
    pb[2] = -64'sd3;
    for (op = 0; op < 8; op = op + 1)
      for (k = 0; k < 3; k = k + 1) begin
        add_br(op, 5'd2, pa[k], pb[k]);
        add_br(op, 5'd3, pa[k], pb[k]);
      end
    for (op = 0; op < 7; op = op + 1)
      add_wb(op, 1, 0, 4'd15, 0, 0);
    add_wb(0, 0, 1, 4'd0, 0, 0);
    add_wb(0, 0, 0, 4'd0, 0, 1);
    add_wb(0, 0, 0, 4'd3, 0, 0);
    add_wb(0, 0, 0, 4'd14, 0, 0);
    add_wb(0, 0, 0, 4'd15, 1, 0);
    limit = 5 + 2 * n + 20;

    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    check_idle();
    i_reset = 1'b0;
    @(negedge i_clk);
    check_idle();
    pend = -1;
    for (i = 0; i < n; i = i + 1) begin
      // a gap in the strobes now and then
      if (i % 7 == 6) begin
        @(negedge i_clk);
        if (pend >= 0) check_entry(pend);
        i_valid = 1'b0;
        pend = -2;
      end
      @(negedge i_clk);
      if (pend == -2) check_idle();
      else if (pend >= 0) check_entry(pend);
      drive(tbl[i]);
      pend = i;
    end
    @(negedge i_clk);
    check_entry(pend);
    i_valid = 1'b0;
    @(negedge i_clk);
    check_idle();

    $display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hw/exu_pkg.sv
hw/exu_ctrl_if.sv
hw/exu_alu.sv
hw/exu_branch.sv
hw/exu_writeback.sv
hw/exu_stage.sv
hw/exu_top.sv
testbench/exu_top_assert.sv
testbench/tb_exu_top.sv

//--- Bender.yml
package:
  name: exu

sources:
  - hw/exu_pkg.sv
  - hw/exu_ctrl_if.sv
  - hw/exu_alu.sv
  - hw/exu_branch.sv
  - hw/exu_writeback.sv
  - hw/exu_stage.sv
  - hw/exu_top.sv
  - target: test
    files:
      - testbench/exu_top_assert.sv
      - testbench/tb_exu_top.sv
